// File: filelist.f
logic/conv1_pkg.sv
logic/conv1_ctrl_fsm.sv
logic/conv1_scan_counter.sv
logic/kernel_buffer.sv
logic/mac_array.sv
logic/relu_quant.sv
logic/conv1_top.sv
sim/sram_model.sv
sim/tb_conv1.sv

// File: logic/conv1_ctrl_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module conv1_ctrl_fsm (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    output logic                  finish,
    input  logic                  w_last,
    input  logic                  row_last,
    input  logic                  tile_last,
    input  logic                  ch_last,
    input  conv1_pkg::addr_t      w_rd_addr0,
    input  conv1_pkg::addr_t      w_rd_addr1,
    input  conv1_pkg::addr_t      act_rd_addr0,
    input  conv1_pkg::addr_t      act_rd_addr1,
    input  conv1_pkg::addr_t      out_addr0,
    input  conv1_pkg::addr_t      out_addr1,
    input  conv1_pkg::word_pair_t quant_out,
    output logic                  w_step,
    output logic                  row_step,
    output logic                  tile_step,
    output logic                  ch_step,
    output logic                  load_en,
    output logic                  acc_clear,
    output logic                  acc_en,
    output conv1_pkg::rd_req_t    weight_req,
    output conv1_pkg::act_req_t   act_req
);

    conv1_pkg::conv_state_t state;
    conv1_pkg::conv_state_t state_next;
    logic                   w_issue;
    logic                   act_issue;
    logic                   write_phase;
    // a read was issued last cycle, so its data is on rdata now
    logic                   w_rd_valid;
    logic                   act_rd_valid;

    assign w_issue     = (state == conv1_pkg::LOAD_W) && !w_last;
    assign act_issue   = (state == conv1_pkg::COMP) && !row_last;
    assign write_phase = (state == conv1_pkg::WRITE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= conv1_pkg::IDLE;
            w_rd_valid   <= 1'b0;
            act_rd_valid <= 1'b0;
            finish       <= 1'b0;
        end else begin
            state        <= state_next;
            w_rd_valid   <= w_issue;
            act_rd_valid <= act_issue;
            finish       <= (state == conv1_pkg::DONE);
        end
    end

    always_comb begin
        state_next = state;
        w_step     = 1'b0;
        row_step   = 1'b0;
        tile_step  = 1'b0;
        ch_step    = 1'b0;
        case (state)
            conv1_pkg::IDLE: begin
                if (start) begin
                    state_next = conv1_pkg::LOAD_W;
                end
            end
            conv1_pkg::LOAD_W: begin
                w_step = 1'b1;
                if (w_last) begin
                    state_next = conv1_pkg::COMP;
                end
            end
            conv1_pkg::COMP: begin
                row_step = 1'b1;
                if (row_last) begin
                    state_next = conv1_pkg::WRITE;
                end
            end
            conv1_pkg::WRITE: begin
                tile_step = 1'b1;
                if (tile_last) begin
                    // channel done, move on or finish
                    ch_step    = 1'b1;
                    state_next = ch_last ? conv1_pkg::DONE : conv1_pkg::LOAD_W;
                end else begin
                    state_next = conv1_pkg::COMP;
                end
            end
            default: begin
                state_next = conv1_pkg::IDLE;
            end
        endcase
    end

    assign load_en   = w_rd_valid;
    assign acc_en    = act_rd_valid;
    // first COMP cycle of a tile, nothing read yet
    assign acc_clear = (state == conv1_pkg::COMP) && !act_rd_valid;

    always_comb begin
        weight_req.cen   = !w_issue;
        weight_req.addr0 = w_rd_addr0;
        weight_req.addr1 = w_rd_addr1;

        act_req.cen    = !(act_issue || write_phase);
        act_req.addr0  = write_phase ? out_addr0 : act_rd_addr0;
        act_req.addr1  = write_phase ? out_addr1 : act_rd_addr1;
        act_req.we0    = write_phase;
        act_req.we1    = write_phase;
        act_req.wdata0 = quant_out.w0;
        act_req.wdata1 = quant_out.w1;
    end

    finish_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) finish |=> !finish
    ) else $error("finish high for more than one cycle");

    no_write_without_cen: assert property (
        @(posedge clk) disable iff (!rst_n) (act_req.we0 || act_req.we1) |-> !act_req.cen
    ) else $error("activation write enable while cen is high");

endmodule

`default_nettype wire

// File: logic/conv1_pkg.sv
`default_nettype none

package conv1_pkg;

    localparam int ADDR_W         = 16;
    localparam int WORD_W         = 32;
    localparam int PIX_W          = 8;
    localparam int PSUM_W         = 32;
    localparam int K              = 5;
    localparam int IMG_W          = 32;
    localparam int TILE_COLS      = WORD_W / PIX_W;
    localparam int OUT_W          = IMG_W - K + 1;
    localparam int N_OCH          = 6;
    localparam int ROW_WORDS      = IMG_W / TILE_COLS;
    localparam int OUT_ROW_WORDS  = OUT_W / TILE_COLS;
    localparam int CH_WORDS       = OUT_W * OUT_ROW_WORDS;
    localparam int W_CH_WORDS     = 2 * K;
    localparam int OUT_BASE       = 1024;
    localparam int TILE_ROWS      = K + 1;
    localparam int LAST_COL       = OUT_W - TILE_COLS;
    localparam int LAST_ROW_START = OUT_W - 2;
    localparam int QUANT_LSB      = 16;
    localparam int QUANT_MAX      = 127;

    typedef logic [ADDR_W-1:0] addr_t;

    typedef struct packed {
        logic [WORD_W-1:0] w1;
        logic [WORD_W-1:0] w0;
    } word_pair_t;

    // tap 0 in the low byte
    typedef logic [K*PIX_W-1:0] kernel_row_t;

    typedef struct packed {
        kernel_row_t bottom;
        kernel_row_t top;
    } kernel_pair_t;

    // [output row][output column]
    typedef logic signed [1:0][TILE_COLS-1:0][PSUM_W-1:0] psum_tile_t;

    typedef struct packed {
        logic  cen;
        addr_t addr0;
        addr_t addr1;
    } rd_req_t;

    typedef struct packed {
        logic              cen;
        addr_t             addr0;
        addr_t             addr1;
        logic              we0;
        logic              we1;
        logic [WORD_W-1:0] wdata0;
        logic [WORD_W-1:0] wdata1;
    } act_req_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_W,
        COMP,
        WRITE,
        DONE
    } conv_state_t;

endpackage

`default_nettype wire

// File: logic/conv1_scan_counter.sv
`timescale 1ns/100ps
`default_nettype none

module conv1_scan_counter (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             w_step,
    input  logic             row_step,
    input  logic             tile_step,
    input  logic             ch_step,
    input  conv1_pkg::addr_t weight_offset,
    input  conv1_pkg::addr_t act_offset,
    output logic             w_last,
    output logic             row_last,
    output logic             tile_last,
    output logic             ch_last,
    output conv1_pkg::addr_t w_rd_addr0,
    output conv1_pkg::addr_t w_rd_addr1,
    output conv1_pkg::addr_t act_rd_addr0,
    output conv1_pkg::addr_t act_rd_addr1,
    output conv1_pkg::addr_t out_addr0,
    output conv1_pkg::addr_t out_addr1,
    output logic [2:0]       w_fill_row,
    output logic [2:0]       calc_row
);

    logic [2:0]       w_cnt;
    logic [2:0]       row_cnt;
    logic [4:0]       col;
    logic [4:0]       row_start;
    logic [2:0]       och;
    conv1_pkg::addr_t in_row;

    assign w_last    = (w_cnt == 3'(conv1_pkg::K));
    assign row_last  = (row_cnt == 3'(conv1_pkg::TILE_ROWS));
    assign tile_last = (col == 5'(conv1_pkg::LAST_COL)) &&
                       (row_start == 5'(conv1_pkg::LAST_ROW_START));
    assign ch_last   = (och == 3'(conv1_pkg::N_OCH - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_cnt      <= '0;
            row_cnt    <= '0;
            col        <= '0;
            row_start  <= '0;
            och        <= '0;
            w_fill_row <= '0;
            calc_row   <= '0;
        end else begin
            if (w_step) begin
                w_cnt <= w_last ? 3'd0 : w_cnt + 3'd1;
            end
            if (row_step) begin
                row_cnt <= row_last ? 3'd0 : row_cnt + 3'd1;
            end
            // columns first, then down two rows
            if (tile_step) begin
                if (col == 5'(conv1_pkg::LAST_COL)) begin
                    col       <= '0;
                    row_start <= tile_last ? 5'd0 : row_start + 5'd2;
                end else begin
                    col <= col + 5'(conv1_pkg::TILE_COLS);
                end
            end
            if (ch_step) begin
                och <= ch_last ? 3'd0 : och + 3'd1;
            end
            // row whose read data shows up next cycle
            w_fill_row <= w_cnt;
            calc_row   <= row_cnt;
        end
    end

    // kernel row r of channel c, 2 words per row
    assign w_rd_addr0 = weight_offset
                      + conv1_pkg::addr_t'(och * conv1_pkg::W_CH_WORDS)
                      + conv1_pkg::addr_t'(2 * w_cnt);
    assign w_rd_addr1 = w_rd_addr0 + conv1_pkg::addr_t'(1);

    assign in_row = conv1_pkg::addr_t'(row_start) + conv1_pkg::addr_t'(row_cnt);

    assign act_rd_addr0 = act_offset
                        + conv1_pkg::addr_t'(in_row * conv1_pkg::ROW_WORDS)
                        + conv1_pkg::addr_t'(col[4:2]);
    assign act_rd_addr1 = act_rd_addr0 + conv1_pkg::addr_t'(1);

    // output row pair, one word of four columns each
    assign out_addr0 = conv1_pkg::addr_t'(conv1_pkg::OUT_BASE)
                     + conv1_pkg::addr_t'(och * conv1_pkg::CH_WORDS)
                     + conv1_pkg::addr_t'(row_start * conv1_pkg::OUT_ROW_WORDS)
                     + conv1_pkg::addr_t'(col[4:2]);
    assign out_addr1 = out_addr0 + conv1_pkg::addr_t'(conv1_pkg::OUT_ROW_WORDS);

    row_cnt_in_range: assert property (
        @(posedge clk) disable iff (!rst_n) row_cnt <= 3'(conv1_pkg::TILE_ROWS)
    ) else $error("tile row count out of range: %0d", row_cnt);

endmodule

`default_nettype wire

// File: logic/conv1_top.sv
`timescale 1ns/100ps
`default_nettype none

module conv1_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    output logic                                finish,
    input  conv1_pkg::addr_t                    weight_offset,
    input  conv1_pkg::addr_t                    act_offset,
    input  logic signed [conv1_pkg::PSUM_W-1:0] scale,
    output conv1_pkg::rd_req_t                  weight_req,
    input  conv1_pkg::word_pair_t               weight_rdata,
    output conv1_pkg::act_req_t                 act_req,
    input  conv1_pkg::word_pair_t               act_rdata
);

    logic                    w_step;
    logic                    row_step;
    logic                    tile_step;
    logic                    ch_step;
    logic                    w_last;
    logic                    row_last;
    logic                    tile_last;
    logic                    ch_last;
    logic                    load_en;
    logic                    acc_clear;
    logic                    acc_en;
    conv1_pkg::addr_t        w_rd_addr0;
    conv1_pkg::addr_t        w_rd_addr1;
    conv1_pkg::addr_t        act_rd_addr0;
    conv1_pkg::addr_t        act_rd_addr1;
    conv1_pkg::addr_t        out_addr0;
    conv1_pkg::addr_t        out_addr1;
    logic [2:0]              w_fill_row;
    logic [2:0]              calc_row;
    conv1_pkg::kernel_pair_t kernel;
    conv1_pkg::psum_tile_t   psum;
    conv1_pkg::word_pair_t   quant_out;

    conv1_ctrl_fsm u_ctrl_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .finish       (finish),
        .w_last       (w_last),
        .row_last     (row_last),
        .tile_last    (tile_last),
        .ch_last      (ch_last),
        .w_rd_addr0   (w_rd_addr0),
        .w_rd_addr1   (w_rd_addr1),
        .act_rd_addr0 (act_rd_addr0),
        .act_rd_addr1 (act_rd_addr1),
        .out_addr0    (out_addr0),
        .out_addr1    (out_addr1),
        .quant_out    (quant_out),
        .w_step       (w_step),
        .row_step     (row_step),
        .tile_step    (tile_step),
        .ch_step      (ch_step),
        .load_en      (load_en),
        .acc_clear    (acc_clear),
        .acc_en       (acc_en),
        .weight_req   (weight_req),
        .act_req      (act_req)
    );

    conv1_scan_counter u_scan_counter (
        .clk           (clk),
        .rst_n         (rst_n),
        .w_step        (w_step),
        .row_step      (row_step),
        .tile_step     (tile_step),
        .ch_step       (ch_step),
        .weight_offset (weight_offset),
        .act_offset    (act_offset),
        .w_last        (w_last),
        .row_last      (row_last),
        .tile_last     (tile_last),
        .ch_last       (ch_last),
        .w_rd_addr0    (w_rd_addr0),
        .w_rd_addr1    (w_rd_addr1),
        .act_rd_addr0  (act_rd_addr0),
        .act_rd_addr1  (act_rd_addr1),
        .out_addr0     (out_addr0),
        .out_addr1     (out_addr1),
        .w_fill_row    (w_fill_row),
        .calc_row      (calc_row)
    );

    kernel_buffer u_kernel_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_en      (load_en),
        .w_fill_row   (w_fill_row),
        .weight_rdata (weight_rdata),
        .calc_row     (calc_row),
        .kernel       (kernel)
    );

    mac_array u_mac_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc_clear (acc_clear),
        .acc_en    (acc_en),
        .act_rdata (act_rdata),
        .kernel    (kernel),
        .psum      (psum)
    );

    relu_quant u_relu_quant (
        .psum      (psum),
        .scale     (scale),
        .quant_out (quant_out)
    );

endmodule

`default_nettype wire

// File: logic/kernel_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module kernel_buffer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load_en,
    input  logic [2:0]              w_fill_row,
    input  conv1_pkg::word_pair_t   weight_rdata,
    input  logic [2:0]              calc_row,
    output conv1_pkg::kernel_pair_t kernel
);

    conv1_pkg::kernel_row_t rows [0:conv1_pkg::K-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < conv1_pkg::K; r++) begin
                rows[r] <= '0;
            end
        end else if (load_en && (w_fill_row < 3'(conv1_pkg::K))) begin
            // bytes 0-3 from w0, byte 4 from low byte of w1
            rows[w_fill_row] <= weight_rdata[conv1_pkg::K*conv1_pkg::PIX_W-1:0];
        end
    end

    // input row r hits output row 0 with kernel row r, output row 1 with r-1
    always_comb begin
        kernel.top    = '0;
        kernel.bottom = '0;
        if (calc_row < 3'(conv1_pkg::K)) begin
            kernel.top = rows[calc_row];
        end
        if ((calc_row >= 3'd1) && (calc_row <= 3'(conv1_pkg::K))) begin
            kernel.bottom = rows[calc_row - 3'd1];
        end
    end

endmodule

`default_nettype wire

// File: logic/mac_array.sv
`timescale 1ns/100ps
`default_nettype none

module mac_array (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    acc_clear,
    input  logic                    acc_en,
    input  conv1_pkg::word_pair_t   act_rdata,
    input  conv1_pkg::kernel_pair_t kernel,
    output conv1_pkg::psum_tile_t   psum
);

    // pixel 0 in the low byte of w0
    logic signed [conv1_pkg::PIX_W-1:0]  pix [0:2*conv1_pkg::TILE_COLS-1];
    logic signed [conv1_pkg::PIX_W-1:0]  wt [0:1][0:conv1_pkg::K-1];
    logic signed [conv1_pkg::PSUM_W-1:0] row_sum [0:1][0:conv1_pkg::TILE_COLS-1];

    always_comb begin
        for (int p = 0; p < 2 * conv1_pkg::TILE_COLS; p++) begin
            pix[p] = act_rdata[p*conv1_pkg::PIX_W +: conv1_pkg::PIX_W];
        end
        for (int t = 0; t < conv1_pkg::K; t++) begin
            wt[0][t] = kernel.top[t*conv1_pkg::PIX_W +: conv1_pkg::PIX_W];
            wt[1][t] = kernel.bottom[t*conv1_pkg::PIX_W +: conv1_pkg::PIX_W];
        end
    end

    // 5-tap dot product per output, sliding one pixel per column
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < conv1_pkg::TILE_COLS; j++) begin
                row_sum[i][j] = '0;
                for (int t = 0; t < conv1_pkg::K; t++) begin
                    row_sum[i][j] += wt[i][t] * pix[j+t];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            psum <= '0;
        end else if (acc_clear) begin
            psum <= '0;
        end else if (acc_en) begin
            for (int i = 0; i < 2; i++) begin
                for (int j = 0; j < conv1_pkg::TILE_COLS; j++) begin
                    psum[i][j] <= psum[i][j] + row_sum[i][j];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/relu_quant.sv
`timescale 1ns/100ps
`default_nettype none

module relu_quant (
    input  conv1_pkg::psum_tile_t               psum,
    input  logic signed [conv1_pkg::PSUM_W-1:0] scale,
    output conv1_pkg::word_pair_t               quant_out
);

    localparam int TOP_BIT = conv1_pkg::QUANT_LSB + conv1_pkg::PIX_W - 1;

    logic signed [conv1_pkg::PSUM_W-1:0]   relu [0:1][0:conv1_pkg::TILE_COLS-1];
    logic signed [2*conv1_pkg::PSUM_W-1:0] prod [0:1][0:conv1_pkg::TILE_COLS-1];
    logic [1:0][conv1_pkg::TILE_COLS-1:0][conv1_pkg::PIX_W-1:0] q;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < conv1_pkg::TILE_COLS; j++) begin
                relu[i][j] = psum[i][j][conv1_pkg::PSUM_W-1] ? '0 : $signed(psum[i][j]);
                prod[i][j] = relu[i][j] * scale;
                // anything above bit 23 means it does not fit, clamp
                if ((prod[i][j] >> TOP_BIT) == '0) begin
                    q[i][j] = prod[i][j][conv1_pkg::QUANT_LSB +: conv1_pkg::PIX_W];
                end else begin
                    q[i][j] = conv1_pkg::PIX_W'(conv1_pkg::QUANT_MAX);
                end
            end
        end
        quant_out.w0 = q[0];
        quant_out.w1 = q[1];
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the conv1 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_conv1 -f filelist.f -Mdir obj_dir \
    || { echo "build failed"; exit 1; }

./obj_dir/Vtb_conv1 | tee /dev/stderr | grep -qx '>>> PASS' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sim/sram_model.sv
`timescale 1ns/100ps
`default_nettype none

module sram_model #(
    parameter int DEPTH = 4096
) (
    input  logic                         clk,
    input  logic                         cen,
    input  conv1_pkg::addr_t             addr0,
    input  conv1_pkg::addr_t             addr1,
    input  logic                         we0,
    input  logic                         we1,
    input  logic [conv1_pkg::WORD_W-1:0] wdata0,
    input  logic [conv1_pkg::WORD_W-1:0] wdata1,
    output conv1_pkg::word_pair_t        rdata
);

    localparam int AW = $clog2(DEPTH);

    logic [conv1_pkg::WORD_W-1:0] mem [0:DEPTH-1];

    // read data one cycle after the request, writes at the same edge
    always @(posedge clk) begin
        if (!cen) begin
            rdata.w0 <= mem[addr0[AW-1:0]];
            rdata.w1 <= mem[addr1[AW-1:0]];
        end
        if (we0) begin
            mem[addr0[AW-1:0]] <= wdata0;
        end
        if (we1) begin
            mem[addr1[AW-1:0]] <= wdata1;
        end
    end

    // backdoor access for the testbench, lands at the end of the time step
    task automatic write_backdoor(input conv1_pkg::addr_t a,
                                  input logic [conv1_pkg::WORD_W-1:0] d);
        mem[a[AW-1:0]] <= d;
    endtask

    function automatic logic [conv1_pkg::WORD_W-1:0] read_backdoor(input conv1_pkg::addr_t a);
        return mem[a[AW-1:0]];
    endfunction

endmodule

`default_nettype wire

// File: sim/tb_conv1.sv
`timescale 1ns/100ps
`default_nettype none

module tb_conv1;

    localparam int MEM_WORDS      = 4096;
    localparam int N_ENTRIES      = 5;
    localparam int IMG            = conv1_pkg::IMG_W;
    localparam int OUT            = conv1_pkg::OUT_W;
    localparam int OUT_END        = conv1_pkg::OUT_BASE + conv1_pkg::N_OCH * conv1_pkg::CH_WORDS;
    localparam int LOAD_CYCLES    = conv1_pkg::K + 1;
    localparam int TILE_CYCLES    = conv1_pkg::TILE_ROWS + 2;
    localparam int N_TILES        = (OUT / 2) * (OUT / 4);
    localparam int FINISH_EDGES   = conv1_pkg::N_OCH * (LOAD_CYCLES + N_TILES * TILE_CYCLES) + 1;
    localparam int TIMEOUT_CYCLES = N_ENTRIES * 4800 + 200;

    localparam logic [1:0] W_RANDOM   = 2'd0;
    localparam logic [1:0] W_NEG      = 2'd1;
    localparam logic [1:0] W_MAX      = 2'd2;
    localparam logic       IMG_RANDOM = 1'b0;
    localparam logic       IMG_MAX    = 1'b1;

    typedef struct packed {
        conv1_pkg::addr_t   weight_offset;
        conv1_pkg::addr_t   act_offset;
        logic signed [31:0] scale;
        logic [1:0]         w_mode;
        logic               img_mode;
        logic               check_sat;
    } test_entry_t;

    // image regions stay clear of the output words 1024..2199
    localparam test_entry_t TESTS [0:N_ENTRIES-1] = '{
        '{16'd0,    16'd0,    32'sd256,   W_RANDOM, IMG_RANDOM, 1'b0},
        '{16'd100,  16'd256,  32'sd64,    W_RANDOM, IMG_RANDOM, 1'b0},
        '{16'd3000, 16'd2304, 32'sd1000,  W_RANDOM, IMG_RANDOM, 1'b0},
        '{16'd500,  16'd3000, 32'sd4096,  W_NEG,    IMG_MAX,    1'b0},
        '{16'd77,   16'd512,  32'sd65536, W_MAX,    IMG_MAX,    1'b1}
    };

    logic                  clk;
    logic                  rst_n;
    logic                  start;
    logic                  finish;
    conv1_pkg::addr_t      weight_offset;
    conv1_pkg::addr_t      act_offset;
    logic signed [31:0]    scale;
    conv1_pkg::rd_req_t    weight_req;
    conv1_pkg::word_pair_t weight_rdata;
    conv1_pkg::act_req_t   act_req;
    conv1_pkg::word_pair_t act_rdata;

    integer             seed;
    int                 cycle_cnt = 0;
    logic signed [7:0]  img [0:IMG-1][0:IMG-1];
    logic signed [7:0]  wgt [0:conv1_pkg::N_OCH-1][0:conv1_pkg::K-1][0:conv1_pkg::K-1];
    logic [31:0]        exp_act [0:MEM_WORDS-1];

    conv1_top u_conv1_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .finish        (finish),
        .weight_offset (weight_offset),
        .act_offset    (act_offset),
        .scale         (scale),
        .weight_req    (weight_req),
        .weight_rdata  (weight_rdata),
        .act_req       (act_req),
        .act_rdata     (act_rdata)
    );

    // weight SRAM is read-only
    sram_model #(.DEPTH(MEM_WORDS)) u_w_mem (
        .clk    (clk),
        .cen    (weight_req.cen),
        .addr0  (weight_req.addr0),
        .addr1  (weight_req.addr1),
        .we0    (1'b0),
        .we1    (1'b0),
        .wdata0 ('0),
        .wdata1 ('0),
        .rdata  (weight_rdata)
    );

    sram_model #(.DEPTH(MEM_WORDS)) u_act_mem (
        .clk    (clk),
        .cen    (act_req.cen),
        .addr0  (act_req.addr0),
        .addr1  (act_req.addr1),
        .we0    (act_req.we0),
        .we1    (act_req.we1),
        .wdata0 (act_req.wdata0),
        .wdata1 (act_req.wdata1),
        .rdata  (act_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not complete within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic expect_bit(input string name, input logic expected, input logic actual);
        assert (actual === expected) else begin
            $display("ERROR %0t %s expected %0b actual %0b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %0t %s expected %08h actual %08h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic init_inputs();
        rst_n         <= 1'b0;
        start         <= 1'b0;
        weight_offset <= '0;
        act_offset    <= '0;
        scale         <= '0;
    endtask

    task automatic apply_reset();
        rst_n <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // ReLU, then keep product bits 23:16 if nothing sits at bit 23 or above
    function automatic logic [7:0] quantize(input int sum, input logic signed [31:0] s);
        logic signed [63:0] prod;
        int                 kept;
        kept = (sum < 0) ? 0 : sum;
        prod = longint'(kept) * longint'(s);
        if (prod[63:23] == '0) begin
            return prod[23:16];
        end
        return 8'd127;
    endfunction

    task automatic fill_memories(input test_entry_t te);
        logic [31:0]      rnd;
        conv1_pkg::addr_t a;
        int               base;
        // background tagged with its own address
        for (int i = 0; i < MEM_WORDS; i++) begin
            a = conv1_pkg::addr_t'(i);
            exp_act[i] = {~a, a};
            u_act_mem.write_backdoor(a, {~a, a});
            u_w_mem.write_backdoor(a, {a, ~a});
        end
        for (int y = 0; y < IMG; y++) begin
            for (int x = 0; x < IMG; x++) begin
                rnd = $random(seed);
                img[y][x] = (te.img_mode == IMG_MAX) ? 8'sd127 : rnd[7:0];
            end
            // pixel x in byte x mod 4
            for (int w = 0; w < conv1_pkg::ROW_WORDS; w++) begin
                base = int'(te.act_offset) + y * conv1_pkg::ROW_WORDS + w;
                exp_act[base] = {img[y][4*w+3], img[y][4*w+2], img[y][4*w+1], img[y][4*w]};
                u_act_mem.write_backdoor(conv1_pkg::addr_t'(base), exp_act[base]);
            end
        end
        for (int c = 0; c < conv1_pkg::N_OCH; c++) begin
            for (int r = 0; r < conv1_pkg::K; r++) begin
                for (int t = 0; t < conv1_pkg::K; t++) begin
                    rnd = $random(seed);
                    case (te.w_mode)
                        W_NEG:   wgt[c][r][t] = {1'b1, rnd[6:0]};
                        W_MAX:   wgt[c][r][t] = 8'sd127;
                        default: wgt[c][r][t] = rnd[7:0];
                    endcase
                end
                // tap 4 in the low byte of the second word, junk above it
                base = int'(te.weight_offset) + c * conv1_pkg::W_CH_WORDS + 2 * r;
                rnd = $random(seed);
                u_w_mem.write_backdoor(conv1_pkg::addr_t'(base),
                    {wgt[c][r][3], wgt[c][r][2], wgt[c][r][1], wgt[c][r][0]});
                u_w_mem.write_backdoor(conv1_pkg::addr_t'(base + 1), {rnd[31:8], wgt[c][r][4]});
            end
        end
    endtask

    task automatic build_golden(input test_entry_t te);
        int acc;
        int a;
        for (int c = 0; c < conv1_pkg::N_OCH; c++) begin
            for (int y = 0; y < OUT; y++) begin
                for (int x = 0; x < OUT; x++) begin
                    acc = 0;
                    for (int r = 0; r < conv1_pkg::K; r++) begin
                        for (int t = 0; t < conv1_pkg::K; t++) begin
                            acc += int'(wgt[c][r][t]) * int'(img[y+r][x+t]);
                        end
                    end
                    a = conv1_pkg::OUT_BASE + c * conv1_pkg::CH_WORDS + y * 7 + x / 4;
                    exp_act[a][8*(x%4) +: 8] = quantize(acc, te.scale);
                end
            end
        end
    endtask

    task automatic check_memory(input test_entry_t te);
        logic [31:0] got;
        logic        in_out;
        for (int a = 0; a < MEM_WORDS; a++) begin
            got    = u_act_mem.read_backdoor(conv1_pkg::addr_t'(a));
            in_out = (a >= conv1_pkg::OUT_BASE) && (a < OUT_END);
            compare_word($sformatf("act_mem[%0d]", a), exp_act[a], got);
            if (in_out && te.check_sat) begin
                compare_word($sformatf("act_mem[%0d] clamp", a), 32'h7f7f_7f7f, got);
            end
            if (in_out && (te.w_mode == W_NEG)) begin
                compare_word($sformatf("act_mem[%0d] relu", a), 32'h0, got);
            end
        end
    endtask

    task automatic run_entry(input int n, input test_entry_t te);
        int edges;
        fill_memories(te);
        build_golden(te);
        @(posedge clk);
        weight_offset <= te.weight_offset;
        act_offset    <= te.act_offset;
        scale         <= te.scale;
        start         <= 1'b1;
        // this edge samples start
        @(posedge clk);
        start <= 1'b0;
        edges = 0;
        @(negedge clk);
        while (finish !== 1'b1) begin
            @(negedge clk);
            edges++;
        end
        assert (edges == FINISH_EDGES) else begin
            $display("ERROR %0t finish latency expected %0d actual %0d",
                     $time, FINISH_EDGES, edges);
            abort_run();
        end
        @(negedge clk);
        expect_bit("finish", 1'b0, finish);
        check_memory(te);
        $display("entry %0d done, scale %0d", n, te.scale);
    endtask

    initial begin
        seed = 32'h246b1def;
        init_inputs();
        apply_reset();
        @(negedge clk);
        expect_bit("act_req.cen", 1'b1, act_req.cen);
        expect_bit("act_req.we0", 1'b0, act_req.we0);
        expect_bit("act_req.we1", 1'b0, act_req.we1);
        expect_bit("weight_req.cen", 1'b1, weight_req.cen);
        expect_bit("finish", 1'b0, finish);
        for (int n = 0; n < N_ENTRIES; n++) begin
            run_entry(n, TESTS[n]);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire
